// ==== spi_card_config.svh ====
`ifndef SPI_CARD_CONFIG_SVH
`define SPI_CARD_CONFIG_SVH

// apb register map, byte offsets
`define APB_ADDR_W      5
`define SPI_ADDR_TX     5'h00
`define SPI_ADDR_RX     5'h04
`define SPI_ADDR_STATUS 5'h08
`define SPI_ADDR_CTRL   5'h0C
`define SPI_ADDR_DIV    5'h10

// sck half period is div+1 int_clk cycles
`define SPI_DIV_W       8
`define SPI_DIV_RESET   3

`endif

// ==== spi_card_pkg.sv ====
`default_nettype none

`include "spi_card_config.svh"

package spi_card_pkg;

  typedef logic [7:0]              data_byte_t;  // one byte on the link
  typedef logic [`SPI_DIV_W-1:0]   sck_div_t;
  typedef logic [`APB_ADDR_W-1:0]  apb_addr_t;
  typedef logic [31:0]             apb_word_t;
  typedef logic [2:0]              bit_cnt_t;

  // shift engine states, one per sck phase plus idle
  typedef enum logic [1:0] {
    IDLE,
    LOW_HALF,
    HIGH_HALF
  } shift_state_t;

endpackage

`default_nettype wire

// ==== spi_byte_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface spi_byte_if import spi_card_pkg::*; ();

  logic       start;    // one cycle, only while !busy
  data_byte_t tx_data;
  sck_div_t   div;
  logic       busy;
  data_byte_t rx_data;
  logic       done;     // one cycle at end of byte

  modport regs (
    output start,
    output tx_data,
    output div,
    input  busy,
    input  rx_data,
    input  done
  );

  modport phy (
    input  start,
    input  tx_data,
    input  div,
    output busy,
    output rx_data,
    output done
  );

endinterface

`default_nettype wire

// ==== spi_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spi_card_config.svh"

module spi_regs import spi_card_pkg::*; (
  input  wire logic      int_clk,
  input  wire logic      rst_n,
  input  wire logic      psel,
  input  wire logic      penable,
  input  wire logic      pwrite,
  input  wire apb_addr_t paddr,
  input  wire apb_word_t pwdata,
  output apb_word_t      prdata,
  output logic           pslverr,
  output logic           cs_n,
  spi_byte_if.regs       bus
);

  logic       access;
  logic       addr_ok;
  logic       tx_collide;
  logic       wr_ok;
  logic       rd_rx;
  logic       cs_en;
  logic       done_flag;
  sck_div_t   div_q;
  data_byte_t tx_q;
  data_byte_t rx_q;

  assign access = psel & penable;

  always_comb begin
    case (paddr)
      `SPI_ADDR_TX, `SPI_ADDR_RX, `SPI_ADDR_STATUS,
      `SPI_ADDR_CTRL, `SPI_ADDR_DIV: addr_ok = 1'b1;
      default:                       addr_ok = 1'b0;
    endcase
  end

  // a tx write during a byte is refused
  assign tx_collide = pwrite & (paddr == `SPI_ADDR_TX) & bus.busy;
  assign pslverr    = access & (~addr_ok | tx_collide);

  assign wr_ok = access & pwrite & ~pslverr;
  assign rd_rx = access & ~pwrite & (paddr == `SPI_ADDR_RX);

  assign bus.start   = wr_ok & (paddr == `SPI_ADDR_TX);
  assign bus.tx_data = pwdata[7:0];  // engine loads it with start
  assign bus.div     = div_q;
  assign cs_n        = ~cs_en;

  always_comb begin
    prdata = '0;
    case (paddr)
      `SPI_ADDR_TX:     prdata = {24'd0, tx_q};
      `SPI_ADDR_RX:     prdata = {24'd0, rx_q};
      `SPI_ADDR_STATUS: prdata = {30'd0, done_flag, bus.busy};
      `SPI_ADDR_CTRL:   prdata = {31'd0, cs_en};
      `SPI_ADDR_DIV:    prdata = {{(32-`SPI_DIV_W){1'b0}}, div_q};
      default:          prdata = '0;
    endcase
  end

  always_ff @(posedge int_clk) begin
    if (!rst_n) begin
      cs_en     <= 1'b0;
      div_q     <= sck_div_t'(`SPI_DIV_RESET);
      done_flag <= 1'b0;
    end else begin
      if (wr_ok && paddr == `SPI_ADDR_CTRL)
        cs_en <= pwdata[0];
      if (wr_ok && paddr == `SPI_ADDR_DIV)
        div_q <= pwdata[`SPI_DIV_W-1:0];
      if (bus.done)
        done_flag <= 1'b1;   // a new byte wins over a read in the same cycle
      else if (rd_rx)
        done_flag <= 1'b0;
    end
  end

  always_ff @(posedge int_clk) begin
    if (bus.start)
      tx_q <= pwdata[7:0];
    if (bus.done)
      rx_q <= bus.rx_data;
  end

  a_start_idle: assert property (@(posedge int_clk) disable iff (!rst_n)
    bus.start |-> !bus.busy)
    else $error("start issued while busy");

  // engine must report busy right after it accepts a byte
  a_start_busy: assert property (@(posedge int_clk) disable iff (!rst_n)
    bus.start |=> bus.busy)
    else $error("busy did not follow start");

endmodule

`default_nettype wire

// ==== spi_shifter.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_shifter import spi_card_pkg::*; (
  input  wire logic int_clk,
  input  wire logic rst_n,
  spi_byte_if.phy   bus,
  output logic      sck,
  output logic      mosi,
  input  wire logic miso
);

  shift_state_t state;
  sck_div_t     div_q;
  sck_div_t     half_cnt;
  bit_cnt_t     bit_cnt;
  data_byte_t   tx_sr;
  data_byte_t   rx_sr;
  data_byte_t   rx_hold;
  logic         sck_q;
  logic         busy_q;
  logic         done_q;
  logic         half_end;

  assign half_end = (half_cnt == div_q);

  assign sck         = sck_q;
  assign mosi        = tx_sr[7];   // msb first
  assign bus.busy    = busy_q;
  assign bus.done    = done_q;
  assign bus.rx_data = rx_hold;

  always_ff @(posedge int_clk) begin
    if (!rst_n) begin
      state    <= IDLE;
      half_cnt <= '0;
      bit_cnt  <= '0;
      tx_sr    <= '0;
      sck_q    <= 1'b0;
      busy_q   <= 1'b0;
      done_q   <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (done_q)
        busy_q <= 1'b0;     // one cycle after sck returns low

      case (state)
        IDLE: begin
          if (bus.start) begin
            tx_sr    <= bus.tx_data;
            half_cnt <= '0;
            bit_cnt  <= '0;
            busy_q   <= 1'b1;
            state    <= LOW_HALF;
          end
        end

        LOW_HALF: begin
          if (half_end) begin
            half_cnt <= '0;
            sck_q    <= 1'b1;   // rising edge
            state    <= HIGH_HALF;
          end else begin
            half_cnt <= half_cnt + 1'b1;
          end
        end

        HIGH_HALF: begin
          if (half_end) begin
            half_cnt <= '0;
            sck_q    <= 1'b0;   // falling edge
            tx_sr    <= {tx_sr[6:0], 1'b0};
            if (bit_cnt == 3'd7) begin
              done_q <= 1'b1;
              state  <= IDLE;
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
              state   <= LOW_HALF;
            end
          end else begin
            half_cnt <= half_cnt + 1'b1;
          end
        end

        default: state <= IDLE;
      endcase
    end
  end

  // divider held for the whole byte
  always_ff @(posedge int_clk) begin
    if (state == IDLE && bus.start)
      div_q <= bus.div;
  end

  always_ff @(posedge int_clk) begin
    if (state == LOW_HALF && half_end)
      rx_sr <= {rx_sr[6:0], miso};   // sample at rising sck
    if (state == HIGH_HALF && half_end && bit_cnt == 3'd7)
      rx_hold <= rx_sr;
  end

  a_start_in_idle: assert property (@(posedge int_clk) disable iff (!rst_n)
    bus.start |-> state == IDLE)
    else $error("start outside idle");

  a_sck_idle_low: assert property (@(posedge int_clk) disable iff (!rst_n)
    state == IDLE |-> !sck_q)
    else $error("sck high while idle");

  a_done_pulse: assert property (@(posedge int_clk) disable iff (!rst_n)
    done_q |=> !done_q)
    else $error("done longer than one cycle");

endmodule

`default_nettype wire

// ==== spi_card_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_card_top import spi_card_pkg::*; (
  input  wire logic      int_clk,
  input  wire logic      rst_n,
  // apb slave, no wait states
  input  wire logic      psel,
  input  wire logic      penable,
  input  wire logic      pwrite,
  input  wire apb_addr_t paddr,
  input  wire apb_word_t pwdata,
  output apb_word_t      prdata,
  output logic           pslverr,
  // spi to the card
  output logic           sck,
  output logic           mosi,
  output logic           cs_n,
  input  wire logic      miso
);

  spi_byte_if bus_if ();

  spi_regs u_regs (
    .int_clk (int_clk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pslverr (pslverr),
    .cs_n    (cs_n),
    .bus     (bus_if.regs)
  );

  spi_shifter u_shifter (
    .int_clk (int_clk),
    .rst_n   (rst_n),
    .bus     (bus_if.phy),
    .sck     (sck),
    .mosi    (mosi),
    .miso    (miso)
  );

endmodule

`default_nettype wire

// ==== spi_card_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spi_card_config.svh"

module spi_card_checker import spi_card_pkg::*; (
  input  wire logic       int_clk,
  input  wire logic       rst_n,
  input  wire logic       psel,
  input  wire logic       penable,
  input  wire logic       pwrite,
  input  wire apb_addr_t  paddr,
  input  wire apb_word_t  prdata,
  input  wire logic       pslverr,
  input  wire logic       sck,
  input  wire logic       mosi,
  input  wire logic       cs_n,
  // expected values from the testbench model
  input  wire logic       exp_err,
  input  wire logic       rd_chk,
  input  wire apb_word_t  exp_rdata,
  input  wire logic       exp_cs_n,
  input  wire sck_div_t   exp_div,
  input  wire logic       byte_chk,
  input  wire data_byte_t exp_tx,
  input  wire data_byte_t slave_got,
  output int              errors
);

  int       err_cnt = 0;
  logic     in_xfer;
  logic     sck_prev;
  int       half_len;
  int       edges;
  sck_div_t div_cap;    // divider of the byte in flight

  assign errors = err_cnt;

  task automatic flag_mismatch(input string sig, input logic [31:0] want,
                               input logic [31:0] got);
    $display("mismatch %s exp %h got %h at %0t", sig, want, got, $time);
    err_cnt++;
  endtask

  task automatic flag_error(input string msg);
    $display("error: %s at %0t", msg, $time);
    err_cnt++;
  endtask

  always @(posedge int_clk) begin
    if (!rst_n) begin
      in_xfer  <= 1'b0;
      sck_prev <= 1'b0;
      half_len <= 0;
      edges    <= 0;
    end else begin
      if (psel && penable) begin
        if (pslverr !== exp_err)
          flag_mismatch("pslverr", 32'(exp_err), 32'(pslverr));
        if (rd_chk && !pwrite && prdata !== exp_rdata)
          flag_mismatch("prdata", exp_rdata, prdata);
      end
      if (cs_n !== exp_cs_n)
        flag_mismatch("cs_n", 32'(exp_cs_n), 32'(cs_n));
      if (byte_chk && slave_got !== exp_tx)
        flag_mismatch("mosi byte", 32'(exp_tx), 32'(slave_got));

      // every sck level lasts div+1 clocks
      if (in_xfer) begin
        if (sck === sck_prev) begin
          half_len <= half_len + 1;
        end else begin
          if (half_len != int'(div_cap) + 1)
            flag_mismatch("sck half period", int'(div_cap) + 1, half_len);
          half_len <= 1;
          edges    <= edges + 1;
          if (edges == 15)
            in_xfer <= 1'b0;   // 16th edge leaves sck low
        end
      end else if (sck !== 1'b0 || mosi !== 1'b0) begin
        flag_error("sck or mosi high between transfers");
      end

      if (psel && penable && pwrite && paddr == `SPI_ADDR_TX && !exp_err) begin
        in_xfer  <= 1'b1;
        div_cap  <= exp_div;
        half_len <= 0;
        edges    <= 0;
      end
      sck_prev <= sck;
    end
  end

endmodule

`default_nettype wire

// ==== tb_spi_card.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spi_card_config.svh"

module tb_spi_card import spi_card_pkg::*; ();

  localparam int N_XFER   = 40;
  localparam int XFER_MAX = 200;   // div 7 byte is 129 cycles plus apb and polling
  localparam int TIMEOUT  = N_XFER * XFER_MAX;

  logic       int_clk;
  logic       rst_n;
  logic       psel;
  logic       penable;
  logic       pwrite;
  apb_addr_t  paddr;
  apb_word_t  pwdata;
  apb_word_t  prdata;
  logic       pslverr;
  logic       sck;
  logic       mosi;
  logic       cs_n;
  logic       miso;

  // model state for the checker
  logic       exp_err;
  logic       rd_chk;
  apb_word_t  exp_rdata;
  logic       exp_cs_n;
  sck_div_t   exp_div;
  logic       byte_chk;
  data_byte_t exp_tx;
  int         errors;

  data_byte_t slave_sr = '0;   // card shift out
  data_byte_t slave_got;       // bits the card saw on mosi
  data_byte_t slave_next;
  logic       slave_load;
  int         cycles = 0;
  int         xfers = 0;

  spi_card_top dut (.*);
  spi_card_checker chk (.*);

  initial begin
    int_clk = 1'b0;
    forever #5 int_clk = ~int_clk;
  end

  // memory card side in mode 0
  assign miso = slave_sr[7];
  always @(negedge sck or posedge slave_load) begin
    if (slave_load)
      slave_sr <= slave_next;
    else
      slave_sr <= {slave_sr[6:0], 1'b0};
  end
  always @(posedge sck)
    slave_got <= {slave_got[6:0], mosi};

  task automatic end_run(input logic timed_out);
    $display("transfers %0d, errors %0d, timeout %0d", xfers, errors, timed_out);
    if (errors == 0 && !timed_out)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  endtask

  always @(posedge int_clk) begin
    cycles = cycles + 1;
    if (cycles == TIMEOUT) begin
      $display("run stopped after %0d cycles without finishing", cycles);
      end_run(1'b1);
    end
  end

  // setup then access cycle from 1 ns after a clock edge
  task automatic apb_access(input logic wr, input apb_addr_t addr, input apb_word_t wdata,
                            input logic err, input logic chk_en, input apb_word_t want,
                            output apb_word_t rdata);
    psel      = 1'b1;
    pwrite    = wr;
    paddr     = addr;
    pwdata    = wdata;
    exp_err   = err;
    rd_chk    = chk_en;
    exp_rdata = want;
    @(posedge int_clk);
    #1 penable = 1'b1;
    @(posedge int_clk);
    rdata = prdata;
    #1 psel = 1'b0;
    penable = 1'b0;
    rd_chk  = 1'b0;
  endtask

  task automatic load_slave(input data_byte_t b);
    slave_next = b;
    slave_load = 1'b1;
    @(posedge int_clk);
    #1 slave_load = 1'b0;
  endtask

  task automatic run_transfer(input int n);
    data_byte_t tx_b;
    data_byte_t sl_b;
    sck_div_t   d;
    logic       cs;
    apb_word_t  rd;
    tx_b = data_byte_t'($urandom);
    sl_b = data_byte_t'($urandom);
    d    = sck_div_t'($urandom_range(7, 0));
    cs   = 1'($urandom);
    load_slave(sl_b);
    apb_access(1'b1, `SPI_ADDR_CTRL, 32'(cs), 1'b0, 1'b0, '0, rd);
    exp_cs_n = ~cs;
    apb_access(1'b1, `SPI_ADDR_DIV, 32'(d), 1'b0, 1'b0, '0, rd);
    exp_div = d;
    exp_tx  = tx_b;
    apb_access(1'b1, `SPI_ADDR_TX, 32'(tx_b), 1'b0, 1'b0, '0, rd);
    if (n % 4 == 1)
      apb_access(1'b1, `SPI_ADDR_TX, 32'(~tx_b), 1'b1, 1'b0, '0, rd);  // refused
    apb_access(1'b0, `SPI_ADDR_TX, '0, 1'b0, 1'b1, 32'(tx_b), rd);
    rd = 32'd1;
    while (rd[0])
      apb_access(1'b0, `SPI_ADDR_STATUS, '0, 1'b0, 1'b0, '0, rd);
    apb_access(1'b0, `SPI_ADDR_STATUS, '0, 1'b0, 1'b1, 32'd2, rd);
    apb_access(1'b0, `SPI_ADDR_RX, '0, 1'b0, 1'b1, 32'(sl_b), rd);
    apb_access(1'b0, `SPI_ADDR_STATUS, '0, 1'b0, 1'b1, 32'd0, rd);
    byte_chk = 1'b1;
    @(posedge int_clk);
    #1 byte_chk = 1'b0;
    xfers++;
  endtask

  initial begin
    apb_word_t rd;
    void'($urandom(27));
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    exp_err    = 1'b0;
    rd_chk     = 1'b0;
    exp_rdata  = '0;
    exp_cs_n   = 1'b1;
    exp_div    = sck_div_t'(`SPI_DIV_RESET);
    byte_chk   = 1'b0;
    exp_tx     = '0;
    slave_next = '0;
    slave_load = 1'b0;
    rst_n      = 1'b0;
    repeat (8) @(posedge int_clk);
    #1 rst_n = 1'b1;

    apb_access(1'b0, `SPI_ADDR_STATUS, '0, 1'b0, 1'b1, 32'd0, rd);
    apb_access(1'b0, `SPI_ADDR_DIV, '0, 1'b0, 1'b1, 32'(`SPI_DIV_RESET), rd);
    for (int i = 0; i < N_XFER; i++)
      run_transfer(i);

    // unmapped offsets leave the divider as it was
    apb_access(1'b1, 5'h14, 32'hFF, 1'b1, 1'b0, '0, rd);
    apb_access(1'b0, 5'h1C, '0, 1'b1, 1'b1, 32'd0, rd);
    apb_access(1'b0, `SPI_ADDR_DIV, '0, 1'b0, 1'b1, 32'(exp_div), rd);
    repeat (2) @(posedge int_clk);
    end_run(1'b0);
  end

endmodule

`default_nettype wire

// ==== spi_card.f ====
+incdir+.
spi_card_pkg.sv
spi_byte_if.sv
spi_regs.sv
spi_shifter.sv
spi_card_top.sv
spi_card_checker.sv
tb_spi_card.sv

// ==== run.sh ====
#!/bin/sh
# build and run the spi card testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_spi_card -f spi_card.f -o tb_spi_card
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_spi_card > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "TEST FAIL" sim.log; then
  exit 1
fi
exit 0
